/* flist.f */
+incdir+common
+incdir+verif
common/arb_pkg.sv
common/xfer_pkg.sv
arbiter/pn_seq_gen.sv
arbiter/grant_arbiter.sv
hw/ingress_stage.sv
hw/xfer_fifo.sv
hw/arb_subsys_top.sv
verif/arb_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= arb_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* verif/arb_ref_model.svh */
`ifndef ARB_REF_MODEL_SVH
`define ARB_REF_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'd87542;

// Expected one-hot grant for one cycle, zero in the idle modes
function automatic logic [3:0] ref_grant(logic [3:0] req, logic [2:0] mode,
                                         logic [1:0] last, logic [1:0] rand_idx);
  logic [3:0] g;
  logic [1:0] head;
  logic [1:0] port;
  g    = 4'b0000;
  head = (mode == 3'd5) ? rand_idx : mode[1:0];
  if (mode <= 3'd3 || mode == 3'd5) begin
    if (req[head]) begin
      g[head] = 1'b1;
    end else begin
      for (int i = 3; i >= 0; i--) begin  // Lowest full port wins
        if (req[i]) begin
          g = 4'b0001 << i;
        end
      end
    end
  end else if (mode == 3'd4) begin
    // Nearest port after the last grant wins
    for (int k = 4; k >= 1; k--) begin
      port = last + 2'(k);
      if (req[port]) begin
        g = 4'b0001 << port;
      end
    end
  end
  return g;
endfunction

function automatic logic [1:0] ref_port(logic [3:0] g);
  case (g)
    4'b0010: return 2'd1;
    4'b0100: return 2'd2;
    4'b1000: return 2'd3;
    default: return 2'd0;
  endcase
endfunction

// State held as {s3, s2, s1}, random head is {s3, s2}
function automatic logic [2:0] pn_step(logic [2:0] st);
  return {st[1], st[0], st[0] ^ st[2]};
endfunction

function automatic logic [31:0] lcg_next(logic [31:0] st);
  return st * 32'd1664525 + 32'd1013904223;
endfunction

`endif

/* verif/arb_tb.sv */
`include "arb_consts.svh"

module arb_tb;

  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_MAX    = 24;
  localparam int RR_CYCLES    = 40;
  localparam int RAND_CYCLES  = 400;
  localparam int FILL_CYCLES  = 16;
  localparam int IDLE_CYCLES  = 10;
  // Ten drains at their limit and seven single load cycles
  localparam int RUN_CYCLES   = 2 * RESET_CYCLES + 10 * DRAIN_MAX + 7 + RR_CYCLES
                              + RAND_CYCLES + FILL_CYCLES + 2 * IDLE_CYCLES + 2;
  localparam int MARGIN       = 100;

  logic                           clk;
  logic                           rst_n;
  logic [3:0]                     in_valid;
  logic [3:0]                     in_ready;
  logic [3:0][`ARB_PAYLOAD_W-1:0] in_data;
  arb_pkg::arb_mode_e             mode;
  logic                           out_valid;
  logic                           out_ready;
  xfer_pkg::xfer_t                out_xfer;

  // Cycle model
  logic [3:0]                     m_full;
  logic [3:0][`ARB_PAYLOAD_W-1:0] m_data;
  logic [1:0]                     m_last;
  logic [2:0]                     m_pn;
  xfer_pkg::xfer_t                exp_q[$];
  logic [1:0]                     src_log[$];  // Sources seen at the output
  logic [1:0]                     exp_order[$];
  int                             accepted;    // Words taken into model slots

  logic [31:0] lcg_state;
  int          checks;
  int          value_errors;
  int          other_errors;

  `include "arb_ref_model.svh"

  arb_subsys_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .mode      (mode),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_xfer  (out_xfer)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] draw_random();
    lcg_state = lcg_next(lcg_state);
    return lcg_state;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic reset_model();
    m_full = 4'b0000;
    m_last = 2'd3;
    m_pn   = 3'b001;
    exp_q.delete();
  endtask

  task automatic compare_outputs();
    logic [3:0] exp_ready;
    exp_ready = ~m_full;
    check_value("in_ready", 32'(exp_ready), 32'(in_ready));
    check_value("out_valid", 32'(exp_q.size() != 0), 32'(out_valid));
    if (out_valid && out_ready) begin
      src_log.push_back(out_xfer.src);
      if (exp_q.size() != 0) begin
        check_value("out_xfer", 32'(exp_q[0]), 32'(out_xfer));
      end
    end
  endtask

  // Model state after the coming rising edge
  task automatic advance_model();
    logic            pop;
    logic            push_ok;
    logic [3:0]      g;
    logic [1:0]      port;
    xfer_pkg::xfer_t x;
    pop     = (exp_q.size() != 0) && out_ready;
    push_ok = (exp_q.size() < `ARB_FIFO_DEPTH) || out_ready;
    g       = push_ok ? ref_grant(m_full, mode, m_last, m_pn[2:1]) : 4'b0000;
    if (pop) begin
      void'(exp_q.pop_front());
    end
    if (g != 4'b0000) begin
      port      = ref_port(g);
      x.src     = port;
      x.payload = m_data[port];
      exp_q.push_back(x);
      m_last = port;
    end
    for (int i = 0; i < 4; i++) begin
      if (g[i]) begin
        m_full[i] = 1'b0;
      end else if (in_valid[i] && !m_full[i]) begin
        m_full[i] = 1'b1;
        m_data[i] = in_data[i];
        accepted++;
      end
    end
    m_pn = pn_step(m_pn);
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      compare_outputs();
      advance_model();
    end
  end

  task automatic wait_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic apply_reset();
    rst_n     = 1'b0;
    in_valid  = 4'b0000;
    out_ready = 1'b1;
    repeat (RESET_CYCLES) wait_cycle();
    rst_n = 1'b1;
  endtask

  task automatic load_ports(logic [3:0] mask);
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
      rnd        = draw_random();
      in_data[i] = rnd[31 -: `ARB_PAYLOAD_W];
    end
    in_valid = mask;
    wait_cycle();
    in_valid = 4'b0000;
  endtask

  task automatic drive_traffic(int cycles, logic rand_valid, logic rand_ready,
                               logic fixed_ready);
    logic [31:0] rnd;
    repeat (cycles) begin
      for (int i = 0; i < 4; i++) begin
        rnd        = draw_random();
        in_data[i] = rnd[31 -: `ARB_PAYLOAD_W];
      end
      rnd       = draw_random();
      in_valid  = rand_valid ? rnd[31:28] : 4'hF;
      out_ready = rand_ready ? rnd[27] : fixed_ready;
      wait_cycle();
    end
  endtask

  // Empties slots and FIFO with the sink ready
  task automatic drain(string what);
    int n;
    n         = 0;
    in_valid  = 4'b0000;
    out_ready = 1'b1;
    while ((exp_q.size() != 0 || m_full != 4'b0000) && n < DRAIN_MAX) begin
      wait_cycle();
      n++;
    end
    if (exp_q.size() != 0 || m_full != 4'b0000) begin
      other_errors++;
      $display("Words still held %0d cycles into the drain after %s", DRAIN_MAX, what);
    end
  endtask

  task automatic check_order(string name, int start);
    check_value({name, " count"}, 32'(exp_order.size()), 32'(src_log.size() - start));
    for (int i = 0; i < exp_order.size() && start + i < src_log.size(); i++) begin
      check_value({name, " source"}, 32'(exp_order[i]), 32'(src_log[start + i]));
    end
  endtask

  initial begin
    logic [2:0] pn;
    logic [3:0] remaining;
    logic [3:0] g;
    int         start;
    int         acc_start;
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 4'b0000;
    in_data      = '0;
    mode         = arb_pkg::ARB_RAND;
    out_ready    = 1'b1;
    lcg_state    = LCG_SEED;
    accepted     = 0;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;

    apply_reset();
    check_value("in_ready", 32'hF, 32'(in_ready));
    check_value("out_valid", 32'd0, 32'(out_valid));

    // First random order starts from PN {1,0,0} stepped once by the load edge
    pn = pn_step(3'b001);
    remaining = 4'hF;
    exp_order.delete();
    repeat (4) begin
      g = ref_grant(remaining, 3'd5, 2'd0, pn[2:1]);
      exp_order.push_back(ref_port(g));
      remaining = remaining & ~g;
      pn = pn_step(pn);
    end
    start = src_log.size();
    load_ports(4'hF);
    drain("first random burst");
    check_order("random after reset", start);

    for (int m = 0; m < 4; m++) begin
      mode = arb_pkg::arb_mode_e'(m);
      exp_order.delete();
      exp_order.push_back(2'(m));  // Head port first and the rest ascending
      for (int i = 0; i < 4; i++) begin
        if (i != m) begin
          exp_order.push_back(2'(i));
        end
      end
      start = src_log.size();
      load_ports(4'hF);
      drain("fixed priority");
      check_order("fixed priority", start);
    end

    mode  = arb_pkg::ARB_RR;
    apply_reset();
    start     = src_log.size();
    acc_start = accepted;
    drive_traffic(RR_CYCLES, 1'b0, 1'b0, 1'b1);
    drain("round robin");
    exp_order.delete();
    for (int i = 0; i < accepted - acc_start; i++) begin
      exp_order.push_back(2'(i % 4));
    end
    check_order("round robin", start);

    // Ports 1 and 3 empty, so they are skipped
    exp_order.delete();
    if (m_last == 2'd0 || m_last == 2'd1) begin
      exp_order.push_back(2'd2);
      exp_order.push_back(2'd0);
    end else begin
      exp_order.push_back(2'd0);
      exp_order.push_back(2'd2);
    end
    start = src_log.size();
    load_ports(4'b0101);
    drain("round robin skip");
    check_order("round robin skip", start);

    mode = arb_pkg::ARB_RAND;
    drive_traffic(RAND_CYCLES, 1'b1, 1'b1, 1'b1);
    drain("random traffic");

    // Sink stalled while every port keeps pushing
    start = src_log.size();
    drive_traffic(FILL_CYCLES, 1'b0, 1'b0, 1'b0);
    check_value("in_ready", 32'd0, 32'(in_ready));
    check_value("out_valid", 32'd1, 32'(out_valid));
    drain("back-pressure");
    check_value("words after stall", 32'd8, 32'(src_log.size() - start));

    start = src_log.size();
    mode  = arb_pkg::arb_mode_e'(3'd6);
    load_ports(4'hF);
    repeat (IDLE_CYCLES) wait_cycle();
    mode = arb_pkg::arb_mode_e'(3'd7);
    repeat (IDLE_CYCLES) wait_cycle();
    check_value("in_ready", 32'd0, 32'(in_ready));
    check_value("out_valid", 32'd0, 32'(out_valid));
    mode = arb_pkg::ARB_FIXED0;
    exp_order.delete();
    for (int i = 0; i < 4; i++) begin
      exp_order.push_back(2'(i));
    end
    drain("idle release");
    check_order("idle release", start);

    repeat (2) wait_cycle();
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(100 * (RUN_CYCLES + MARGIN));
    $display("Timeout: the run did not end within %0d cycles", RUN_CYCLES + MARGIN);
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors + 1);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* hw/arb_subsys_top.sv */
`include "arb_consts.svh"

module arb_subsys_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [3:0]                     in_valid,
  output logic [3:0]                     in_ready,
  input  logic [3:0][`ARB_PAYLOAD_W-1:0] in_data,
  input  arb_pkg::arb_mode_e             mode,
  output logic                           out_valid,
  input  logic                           out_ready,
  output xfer_pkg::xfer_t                out_xfer
);

  logic            push_valid;
  logic            push_ready;
  xfer_pkg::xfer_t push_xfer;

  // Slots and arbiter
  ingress_stage u_ingress (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .mode       (mode),
    .push_ready (push_ready),
    .push_valid (push_valid),
    .push_xfer  (push_xfer)
  );

  // FIFO head feeds the output stream directly
  xfer_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_xfer  (push_xfer),
    .push_ready (push_ready),
    .pop_valid  (out_valid),
    .pop_xfer   (out_xfer),
    .pop_ready  (out_ready)
  );

endmodule

/* hw/xfer_fifo.sv */
`include "arb_consts.svh"

module xfer_fifo (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            push_valid,
  input  xfer_pkg::xfer_t push_xfer,
  output logic            push_ready,
  output logic            pop_valid,
  output xfer_pkg::xfer_t pop_xfer,
  input  logic            pop_ready
);

  typedef logic [`ARB_FIFO_PTR_W-1:0] ptr_t;
  typedef logic [`ARB_FIFO_PTR_W:0]   cnt_t;

  xfer_pkg::xfer_t mem [`ARB_FIFO_DEPTH];
  ptr_t            wr_ptr;
  ptr_t            rd_ptr;
  cnt_t            count;
  logic            full;
  logic            do_push;
  logic            do_pop;

  assign full      = (count == cnt_t'(`ARB_FIFO_DEPTH));
  assign pop_valid = (count != '0);
  assign pop_xfer  = mem[rd_ptr];

  // A pop in the same cycle frees a slot for the push
  assign push_ready = ~full | pop_ready;

  assign do_push = push_valid & push_ready;
  assign do_pop  = pop_valid & pop_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_xfer;
    end
  end

endmodule

/* hw/ingress_stage.sv */
`include "arb_consts.svh"

module ingress_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [3:0]                     in_valid,
  output logic [3:0]                     in_ready,
  input  logic [3:0][`ARB_PAYLOAD_W-1:0] in_data,
  input  arb_pkg::arb_mode_e             mode,
  input  logic                           push_ready,
  output logic                           push_valid,
  output xfer_pkg::xfer_t                push_xfer
);

  logic [3:0]                     slot_full;
  logic [3:0][`ARB_PAYLOAD_W-1:0] slot_data;
  logic [3:0]                     accept;
  arb_pkg::grant_t                grant;
  logic [1:0]                     src_idx;

  assign in_ready = ~slot_full;  // Ready only into an empty slot
  assign accept   = in_valid & in_ready;

  grant_arbiter u_arb (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (slot_full),
    .mode   (mode),
    .enable (push_ready),
    .grant  (grant)
  );

  assign src_idx    = arb_pkg::grant_idx(grant);
  assign push_valid = |grant;

  always_comb begin
    push_xfer.src     = src_idx;
    push_xfer.payload = slot_data[src_idx];
  end

  // Granted slot empties at the push edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_full <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (grant[i]) begin
          slot_full[i] <= 1'b0;
        end else if (accept[i]) begin
          slot_full[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (accept[i]) begin
        slot_data[i] <= in_data[i];
      end
    end
  end

endmodule

/* arbiter/grant_arbiter.sv */
module grant_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [3:0]         req,
  input  arb_pkg::arb_mode_e mode,
  input  logic               enable,
  output arb_pkg::grant_t    grant
);

  logic [1:0]      rand_idx;
  logic [1:0]      last_idx;   // Port granted most recently
  arb_pkg::grant_t rr_grant;
  arb_pkg::grant_t sel_grant;

  // Head port first, then the rest in ascending order
  function automatic arb_pkg::grant_t fixed_pri(logic [3:0] r, logic [1:0] head);
    arb_pkg::grant_t g;
    g = '0;
    if (r[head]) begin
      g[head] = 1'b1;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (r[i] && g == '0) begin
          g[i] = 1'b1;
        end
      end
    end
    return g;
  endfunction

  // Ascending search, wrapping, starting after the last grant
  function automatic arb_pkg::grant_t round_robin(logic [3:0] r, logic [1:0] last);
    arb_pkg::grant_t g;
    logic [1:0]      idx;
    g = '0;
    for (int k = 1; k <= 4; k++) begin
      idx = last + 2'(k);
      if (r[idx] && g == '0) begin
        g[idx] = 1'b1;
      end
    end
    return g;
  endfunction

  pn_seq_gen u_pn (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  assign rr_grant = round_robin(req, last_idx);

  always_comb begin
    case (mode)
      arb_pkg::ARB_FIXED0,
      arb_pkg::ARB_FIXED1,
      arb_pkg::ARB_FIXED2,
      arb_pkg::ARB_FIXED3: sel_grant = fixed_pri(req, mode[1:0]);
      arb_pkg::ARB_RR:     sel_grant = rr_grant;
      arb_pkg::ARB_RAND:   sel_grant = fixed_pri(req, rand_idx);
      default:             sel_grant = '0;  // Idle modes
    endcase
  end

  // No grant while the FIFO cannot take the word
  assign grant = enable ? sel_grant : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_idx <= 2'd3;  // Port 0 goes first
    end else if (grant != '0) begin
      last_idx <= arb_pkg::grant_idx(grant);
    end
  end

endmodule

/* arbiter/pn_seq_gen.sv */
module pn_seq_gen (
  input  logic       clk,
  input  logic       rst_n,
  output logic [1:0] rand_idx
);

  logic s1;
  logic s2;
  logic s3;
  logic s0;

  assign s0 = s1 ^ s3;  // Feedback tap

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= s0;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_idx = {s3, s2};

endmodule

/* common/xfer_pkg.sv */
`include "arb_consts.svh"

package xfer_pkg;

  // One word as it leaves the ingress stage
  typedef struct packed {
    logic [1:0]                src;      // Granted port
    logic [`ARB_PAYLOAD_W-1:0] payload;
  } xfer_t;

endpackage

/* common/arb_pkg.sv */
package arb_pkg;

  // Values 6 and 7 are left unnamed and mean idle
  typedef enum logic [2:0] {
    ARB_FIXED0 = 3'd0,
    ARB_FIXED1 = 3'd1,
    ARB_FIXED2 = 3'd2,
    ARB_FIXED3 = 3'd3,
    ARB_RR     = 3'd4,
    ARB_RAND   = 3'd5
  } arb_mode_e;

  typedef logic [3:0] grant_t;  // One-hot, zero when idle

  // Port number of a one-hot grant
  function automatic logic [1:0] grant_idx(grant_t g);
    logic [1:0] idx;
    idx = '0;
    for (int i = 0; i < 4; i++) begin
      if (g[i]) begin
        idx = 2'(i);
      end
    end
    return idx;
  endfunction

endpackage

/* common/arb_consts.svh */
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// Requester word width
`define ARB_PAYLOAD_W 16

`define ARB_FIFO_DEPTH 4
`define ARB_FIFO_PTR_W 2  // log2 of FIFO depth

`endif
